/* logic/lane_cfg_pkg.sv */
package lane_cfg_pkg;

   ////////////////////
   // Lane geometry
   ////////////////////

   localparam int BYTE_W = 8;             // One lane byte
   localparam int WORD_W = 32;            // One lane word, four bytes

   localparam int SLIDE_AMT_W = 8;

   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [WORD_W-1:0] word_t;

   ////////////////////
   // Element width
   ////////////////////

   // How many neighbouring lanes share one element
   //   SEW_8  one lane per element
   //   SEW_16 a lane pair
   //   SEW_32 a group of four lanes
   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_e;

endpackage

/* logic/lane_op_pkg.sv */
package lane_op_pkg;

   ////////////////////
   // Encodings
   ////////////////////

   typedef enum logic [2:0] {
      ADD  = 3'd0,
      SUB  = 3'd1,
      AND  = 3'd2,
      OR   = 3'd3,
      XOR  = 3'd4,
      MUL  = 3'd5,                        // Low part only
      MACC = 3'd6                         // a * b + c
   } opcode_e;

   typedef enum logic [1:0] {
      OP2_VECTOR = 2'd0,
      OP2_SCALAR = 2'd1,
      OP2_IMM    = 2'd2
   } op2_src_e;

   ////////////////////
   // Command side
   ////////////////////

   typedef struct packed {
      opcode_e             opcode;
      op2_src_e            op2_src;
      lane_cfg_pkg::sew_e  sew;
      lane_cfg_pkg::word_t scalar;
      logic [4:0]          imm;           // Sign-extended on use
   } issue_cmd_t;

   typedef struct packed {
      logic                                 dir_up;
      logic [lane_cfg_pkg::SLIDE_AMT_W-1:0] amount;
      logic [1:0]                           byte_sel;
   } slide_cmd_t;

   ////////////////////
   // Datapath control
   ////////////////////

   typedef struct packed {
      logic               valid;
      opcode_e            opcode;
      lane_cfg_pkg::sew_e sew;
   } alu_ctrl_t;

   // B operand already resolved
   typedef struct packed {
      logic                use_vector;
      lane_cfg_pkg::word_t broadcast;
   } op2_ctrl_t;

   typedef struct packed {
      logic                                 valid;
      logic                                 dir_up;
      logic [lane_cfg_pkg::SLIDE_AMT_W-1:0] amount;
      logic [1:0]                           byte_sel;
   } slide_exec_t;

endpackage

/* logic/lane_issue_ctrl.sv */
`timescale 1ns/1ps

module lane_issue_ctrl
#(
   parameter int READ_DELAY = 3
)
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     issue_i,
   input  lane_op_pkg::issue_cmd_t  issue_cmd_i,
   input  logic                     slide_i,
   input  lane_op_pkg::slide_cmd_t  slide_cmd_i,
   output lane_op_pkg::alu_ctrl_t   alu_ctrl_o,
   output lane_op_pkg::op2_ctrl_t   op2_ctrl_o,
   output lane_op_pkg::slide_exec_t slide_exec_o
);

   import lane_cfg_pkg::*;
   import lane_op_pkg::*;

   alu_ctrl_t   alu_in;
   op2_ctrl_t   op2_in;
   slide_exec_t slide_in;
   word_t       imm_sext;

   // One entry per cycle of register-file latency
   alu_ctrl_t   alu_pipe   [READ_DELAY];
   op2_ctrl_t   op2_pipe   [READ_DELAY];
   slide_exec_t slide_pipe [READ_DELAY];

   ////////////////////
   // Pipeline entry
   ////////////////////

   assign imm_sext = {{(WORD_W-5){issue_cmd_i.imm[4]}}, issue_cmd_i.imm};

   always_comb
   begin
      alu_in.valid  = issue_i;
      alu_in.opcode = issue_cmd_i.opcode;
      alu_in.sew    = issue_cmd_i.sew;

      // Anything but vector B becomes a broadcast word
      op2_in.use_vector = (issue_cmd_i.op2_src == OP2_VECTOR);
      op2_in.broadcast  = (issue_cmd_i.op2_src == OP2_IMM) ? imm_sext : issue_cmd_i.scalar;

      slide_in.valid    = slide_i & ~issue_i;   // Issue wins the cycle
      slide_in.dir_up   = slide_cmd_i.dir_up;
      slide_in.amount   = slide_cmd_i.amount;
      slide_in.byte_sel = slide_cmd_i.byte_sel;
   end

   ////////////////////
   // Delay line
   ////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         for (int i = 0; i < READ_DELAY; i++)
         begin
            alu_pipe[i]   <= '0;
            slide_pipe[i] <= '0;
         end
      end
      else
      begin
         alu_pipe[0]   <= alu_in;
         slide_pipe[0] <= slide_in;
         for (int i = 1; i < READ_DELAY; i++)
         begin
            alu_pipe[i]   <= alu_pipe[i-1];
            slide_pipe[i] <= slide_pipe[i-1];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      op2_pipe[0] <= op2_in;
      for (int i = 1; i < READ_DELAY; i++)
         op2_pipe[i] <= op2_pipe[i-1];
   end

   // Last stage lines up with the operand words
   assign alu_ctrl_o   = alu_pipe[READ_DELAY-1];
   assign op2_ctrl_o   = op2_pipe[READ_DELAY-1];
   assign slide_exec_o = slide_pipe[READ_DELAY-1];

endmodule

/* logic/operand_regroup.sv */
`timescale 1ns/1ps

module operand_regroup
#(
   parameter int NUM_LANES = 8
)
(
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs1_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs2_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs3_i,
   input  lane_cfg_pkg::sew_e                  sew_i,
   input  lane_op_pkg::op2_ctrl_t              op2_ctrl_i,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] alu_a_o,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] alu_b_o,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] alu_c_o
);

   import lane_cfg_pkg::*;

   typedef word_t [NUM_LANES-1:0] lane_vec_t;

   lane_vec_t vs2_grp;

   // Gathers the bytes of one element from its lane group
   function automatic lane_vec_t regroup(input lane_vec_t vs, input sew_e sew);
      lane_vec_t grp;
      int        base;
      int        j;
      grp = '0;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         case (sew)
            SEW_8:
               grp[k][BYTE_W-1:0] = vs[k][BYTE_W-1:0];
            SEW_16:
            begin
               base = k - (k % 2);
               j    = k % 2;                    // Byte j of the pair
               grp[k][BYTE_W-1:0]        = vs[base][j*BYTE_W +: BYTE_W];
               grp[k][2*BYTE_W-1:BYTE_W] = vs[base+1][j*BYTE_W +: BYTE_W];
            end
            SEW_32:
            begin
               base = k - (k % 4);
               j    = k % 4;
               for (int m = 0; m < 4; m++)
                  grp[k][m*BYTE_W +: BYTE_W] = vs[base+m][j*BYTE_W +: BYTE_W];
            end
            default:
               grp[k] = '0;
         endcase
      end
      return grp;
   endfunction

   always_comb
   begin
      alu_a_o = regroup(vs1_i, sew_i);
      vs2_grp = regroup(vs2_i, sew_i);
      alu_c_o = regroup(vs3_i, sew_i);

      // Scalar or immediate goes to every ALU unchanged
      for (int k = 0; k < NUM_LANES; k++)
         alu_b_o[k] = op2_ctrl_i.use_vector ? vs2_grp[k] : op2_ctrl_i.broadcast;
   end

endmodule

/* logic/element_alu.sv */
`timescale 1ns/1ps

module element_alu
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  lane_op_pkg::alu_ctrl_t ctrl_i,
   input  lane_cfg_pkg::word_t    a_i,
   input  lane_cfg_pkg::word_t    b_i,
   input  lane_cfg_pkg::word_t    c_i,
   output logic                   valid_o,
   output lane_cfg_pkg::sew_e     sew_o,
   output lane_cfg_pkg::word_t    res_o
);

   import lane_cfg_pkg::*;
   import lane_op_pkg::*;

   word_t full_res;
   word_t trunc_res;

   always_comb
   begin
      case (ctrl_i.opcode)
         ADD:     full_res = a_i + b_i;
         SUB:     full_res = a_i - b_i;
         AND:     full_res = a_i & b_i;
         OR:      full_res = a_i | b_i;
         XOR:     full_res = a_i ^ b_i;
         MUL:     full_res = a_i * b_i;          // Upper half dropped
         MACC:    full_res = a_i * b_i + c_i;
         default: full_res = '0;
      endcase
   end

   // Keep only the element bits, zero above
   always_comb
   begin
      case (ctrl_i.sew)
         SEW_8:   trunc_res = {{(WORD_W-BYTE_W){1'b0}}, full_res[BYTE_W-1:0]};
         SEW_16:  trunc_res = {{(WORD_W-2*BYTE_W){1'b0}}, full_res[2*BYTE_W-1:0]};
         default: trunc_res = full_res;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= ctrl_i.valid;
   end

   always_ff @(posedge clk_i)
   begin
      if (ctrl_i.valid)
      begin
         res_o <= trunc_res;
         sew_o <= ctrl_i.sew;                    // Scatter needs it next cycle
      end
   end

endmodule

/* logic/result_scatter.sv */
`timescale 1ns/1ps

module result_scatter
#(
   parameter int NUM_LANES = 8
)
(
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] res_i,
   input  lane_cfg_pkg::sew_e  [NUM_LANES-1:0] sew_i,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] lane_res_o
);

   import lane_cfg_pkg::*;

   ////////////////////
   // Inverse of regroup
   ////////////////////

   always_comb
   begin
      int    base4;
      int    base2;
      byte_t lo_b;
      byte_t hi_b;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         base4 = k - (k % 4);
         base2 = k - (k % 2);
         lo_b  = res_i[base2][(k % 2)*BYTE_W +: BYTE_W];
         hi_b  = res_i[base2+1][(k % 2)*BYTE_W +: BYTE_W];

         // Mode taken from the first lane of each group
         if (sew_i[base4] == SEW_32)
         begin
            for (int j = 0; j < 4; j++)
               lane_res_o[k][j*BYTE_W +: BYTE_W] = res_i[base4+j][(k % 4)*BYTE_W +: BYTE_W];
         end
         else if (sew_i[base2] == SEW_16)
            lane_res_o[k] = {hi_b, lo_b, hi_b, lo_b};     // Pair repeated in upper half
         else
            lane_res_o[k] = {4{res_i[k][BYTE_W-1:0]}};
      end
   end

endmodule

/* logic/slide_xbar.sv */
`timescale 1ns/1ps

module slide_xbar
#(
   parameter int NUM_LANES = 8
)
(
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  lane_op_pkg::slide_exec_t            exec_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs2_i,
   output logic                                valid_o,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] data_o
);

   import lane_cfg_pkg::*;

   localparam int LANE_W = $clog2(NUM_LANES);

   logic  [LANE_W-1:0]    amt;
   word_t [NUM_LANES-1:0] slide_d;

   assign amt = exec_i.amount[LANE_W-1:0];       // Wraps modulo NUM_LANES

   always_comb
   begin
      logic [LANE_W-1:0] src;
      byte_t             sel_b;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         src        = exec_i.dir_up ? LANE_W'(k) - amt : LANE_W'(k) + amt;
         sel_b      = vs2_i[src][exec_i.byte_sel*BYTE_W +: BYTE_W];
         slide_d[k] = {4{sel_b}};
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else
         valid_o <= exec_i.valid;
   end

   always_ff @(posedge clk_i)
   begin
      if (exec_i.valid)
         data_o <= slide_d;
   end

endmodule

/* logic/lane_cluster_top.sv */
`timescale 1ns/1ps

module lane_cluster_top
#(
   parameter int NUM_LANES  = 8,
   parameter int READ_DELAY = 3
)
(
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                issue_i,
   input  lane_op_pkg::issue_cmd_t             issue_cmd_i,
   input  logic                                slide_i,
   input  lane_op_pkg::slide_cmd_t             slide_cmd_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs1_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs2_i,
   input  lane_cfg_pkg::word_t [NUM_LANES-1:0] vs3_i,
   output logic                                res_valid_o,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] res_o,
   output logic                                slide_valid_o,
   output lane_cfg_pkg::word_t [NUM_LANES-1:0] slide_data_o
);

   import lane_cfg_pkg::*;
   import lane_op_pkg::*;

   alu_ctrl_t   alu_ctrl;
   op2_ctrl_t   op2_ctrl;
   slide_exec_t slide_exec;

   word_t [NUM_LANES-1:0] alu_a;
   word_t [NUM_LANES-1:0] alu_b;
   word_t [NUM_LANES-1:0] alu_c;
   word_t [NUM_LANES-1:0] alu_res;
   sew_e  [NUM_LANES-1:0] alu_sew;
   logic  [NUM_LANES-1:0] alu_valid;

   ////////////////////
   // Control
   ////////////////////

   lane_issue_ctrl #(.READ_DELAY(READ_DELAY)) issue_ctrl_inst
   (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .issue_i      (issue_i),
      .issue_cmd_i  (issue_cmd_i),
      .slide_i      (slide_i),
      .slide_cmd_i  (slide_cmd_i),
      .alu_ctrl_o   (alu_ctrl),
      .op2_ctrl_o   (op2_ctrl),
      .slide_exec_o (slide_exec)
   );

   ////////////////////
   // Element datapath
   ////////////////////

   operand_regroup #(.NUM_LANES(NUM_LANES)) regroup_inst
   (
      .vs1_i      (vs1_i),
      .vs2_i      (vs2_i),
      .vs3_i      (vs3_i),
      .sew_i      (alu_ctrl.sew),
      .op2_ctrl_i (op2_ctrl),
      .alu_a_o    (alu_a),
      .alu_b_o    (alu_b),
      .alu_c_o    (alu_c)
   );

   for (genvar i = 0; i < NUM_LANES; i++)
   begin : gen_alu
      element_alu alu_inst
      (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .ctrl_i  (alu_ctrl),                    // Same command to every lane
         .a_i     (alu_a[i]),
         .b_i     (alu_b[i]),
         .c_i     (alu_c[i]),
         .valid_o (alu_valid[i]),
         .sew_o   (alu_sew[i]),
         .res_o   (alu_res[i])
      );
   end

   result_scatter #(.NUM_LANES(NUM_LANES)) scatter_inst
   (
      .res_i      (alu_res),
      .sew_i      (alu_sew),
      .lane_res_o (res_o)
   );

   // All lanes run in lockstep
   assign res_valid_o = alu_valid[0];

   ////////////////////
   // Slide path
   ////////////////////

   slide_xbar #(.NUM_LANES(NUM_LANES)) xbar_inst
   (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .exec_i  (slide_exec),
      .vs2_i   (vs2_i),
      .valid_o (slide_valid_o),
      .data_o  (slide_data_o)
   );

endmodule

/* verification/lane_model.svh */
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

typedef word_t [NUM_LANES-1:0] lane_vec_t;

logic [15:0] lfsr_state;                       // x^16 + x^14 + x^13 + x^11 + 1

////////////////////
// Random source
////////////////////

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++)
   begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v          = {v[30:0], fb};
   end
   return v;
endfunction

function automatic lane_vec_t rand_lanes();
   lane_vec_t v;
   for (int k = 0; k < NUM_LANES; k++)
      v[k] = rand_bits(WORD_W);
   return v;
endfunction

////////////////////
// Reference rules
////////////////////

// Lanes per element, 1 2 or 4
function automatic int group_size(input sew_e sew);
   return 1 << int'(sew);
endfunction

// ALU base+j byte m comes from lane base+m byte j
function automatic lane_vec_t gather_elems(input lane_vec_t vs, input int g);
   lane_vec_t out;
   int        base;
   out = '0;
   for (int k = 0; k < NUM_LANES; k++)
   begin
      base = k - k % g;
      for (int m = 0; m < g; m++)
         out[k][BYTE_W*m +: BYTE_W] = vs[base+m][BYTE_W*(k % g) +: BYTE_W];
   end
   return out;
endfunction

// Lane base+m byte b comes from ALU base+(b mod g) byte m
function automatic lane_vec_t scatter_elems(input lane_vec_t r, input int g);
   lane_vec_t out;
   int        base;
   for (int k = 0; k < NUM_LANES; k++)
   begin
      base = k - k % g;
      for (int b = 0; b < 4; b++)
         out[k][BYTE_W*b +: BYTE_W] = r[base + b % g][BYTE_W*(k % g) +: BYTE_W];
   end
   return out;
endfunction

function automatic word_t alu_model(input opcode_e op, input int g, input word_t a,
                                    input word_t b, input word_t c);
   word_t r;
   case (op)
      ADD:     r = a + b;
      SUB:     r = a - b;
      AND:     r = a & b;
      OR:      r = a | b;
      XOR:     r = a ^ b;
      MUL:     r = a * b;
      MACC:    r = a * b + c;
      default: r = '0;
   endcase
   return r & word_t'((64'd1 << (BYTE_W*g)) - 64'd1);   // Element bits only
endfunction

function automatic lane_vec_t expect_result(input issue_cmd_t cmd, input lane_vec_t vs1,
                                            input lane_vec_t vs2, input lane_vec_t vs3);
   lane_vec_t a;
   lane_vec_t b;
   lane_vec_t c;
   lane_vec_t r;
   word_t     bc;
   int        g;
   g  = group_size(cmd.sew);
   a  = gather_elems(vs1, g);
   b  = gather_elems(vs2, g);
   c  = gather_elems(vs3, g);
   bc = (cmd.op2_src == OP2_IMM) ? {{27{cmd.imm[4]}}, cmd.imm} : cmd.scalar;
   for (int k = 0; k < NUM_LANES; k++)
   begin
      if (cmd.op2_src != OP2_VECTOR)
         b[k] = bc;
      r[k] = alu_model(cmd.opcode, g, a[k], b[k], c[k]);
   end
   return scatter_elems(r, g);
endfunction

function automatic lane_vec_t expect_slide(input slide_cmd_t sc, input lane_vec_t vs2);
   lane_vec_t out;
   int        src;
   for (int k = 0; k < NUM_LANES; k++)
   begin
      src    = sc.dir_up ? k - int'(sc.amount) : k + int'(sc.amount);
      src    = ((src % NUM_LANES) + NUM_LANES) % NUM_LANES;
      out[k] = {4{vs2[src][BYTE_W*sc.byte_sel +: BYTE_W]}};
   end
   return out;
endfunction

`endif

/* verification/tb_lane_cluster.sv */
`timescale 1ns/1ps

module tb_lane_cluster;

   import lane_cfg_pkg::*;
   import lane_op_pkg::*;

   localparam int NUM_LANES      = 8;
   localparam int READ_DELAY     = 3;
   localparam int TEST_STEPS     = 3*7 + 3*7*2 + 2*4*2 + 40;   // Gaps and drain in the 40
   localparam int TIMEOUT_CYCLES = 16*TEST_STEPS;

   `include "lane_model.svh"

   typedef struct packed {
      logic       issue;
      logic       slide;
      issue_cmd_t icmd;
      slide_cmd_t scmd;
      lane_vec_t  vs1;
      lane_vec_t  vs2;
      lane_vec_t  vs3;
   } pending_t;

   typedef struct packed {
      logic      res_valid;
      lane_vec_t res;
      logic      slide_valid;
      lane_vec_t slide;
   } expect_t;

   logic       clk_i;
   logic       rst_i;
   logic       issue_i;
   issue_cmd_t issue_cmd_i;
   logic       slide_i;
   slide_cmd_t slide_cmd_i;
   lane_vec_t  vs1_i;
   lane_vec_t  vs2_i;
   lane_vec_t  vs3_i;
   logic       res_valid_o;
   lane_vec_t  res_o;
   logic       slide_valid_o;
   lane_vec_t  slide_data_o;

   pending_t pend_q[$];                        // Commands waiting for their operands
   expect_t  exp_d;
   expect_t  exp_q;
   int       res_errors;
   int       slide_errors;
   int       res_checked;
   int       slide_checked;
   int       cycle_cnt;

   lane_cluster_top #(.NUM_LANES(NUM_LANES), .READ_DELAY(READ_DELAY)) dut0
   (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .issue_i       (issue_i),
      .issue_cmd_i   (issue_cmd_i),
      .slide_i       (slide_i),
      .slide_cmd_i   (slide_cmd_i),
      .vs1_i         (vs1_i),
      .vs2_i         (vs2_i),
      .vs3_i         (vs3_i),
      .res_valid_o   (res_valid_o),
      .res_o         (res_o),
      .slide_valid_o (slide_valid_o),
      .slide_data_o  (slide_data_o)
   );

   always #4 clk_i = ~clk_i;

   // Expected outputs trail the operand drive by one cycle
   always @(posedge clk_i)
   begin
      if (!rst_i)
         exp_q <= '0;
      else
         exp_q <= exp_d;
   end

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   res_valid_chk: assert property (@(negedge clk_i) disable iff (!rst_i)
      res_valid_o == exp_q.res_valid)
   else
   begin
      res_errors = res_errors + 1;
      $display("Fail %0t res_valid_o: expected %b, got %b", $time, exp_q.res_valid, res_valid_o);
   end

   res_data_chk: assert property (@(negedge clk_i) disable iff (!rst_i)
      exp_q.res_valid |-> res_o == exp_q.res)
   else
   begin
      res_errors = res_errors + 1;
      $display("Fail %0t res_o: expected %h, got %h", $time, exp_q.res, res_o);
   end

   slide_valid_chk: assert property (@(negedge clk_i) disable iff (!rst_i)
      slide_valid_o == exp_q.slide_valid)
   else
   begin
      slide_errors = slide_errors + 1;
      $display("Fail %0t slide_valid_o: expected %b, got %b", $time, exp_q.slide_valid,
               slide_valid_o);
   end

   slide_data_chk: assert property (@(negedge clk_i) disable iff (!rst_i)
      exp_q.slide_valid |-> slide_data_o == exp_q.slide)
   else
   begin
      slide_errors = slide_errors + 1;
      $display("Fail %0t slide_data_o: expected %h, got %h", $time, exp_q.slide, slide_data_o);
   end

   ////////////////////
   // Stimulus
   ////////////////////

   // One cycle of strobes with the register file answering READ_DELAY cycles late
   task automatic drive_cycle(input logic iss, input issue_cmd_t ic, input logic sld,
                              input slide_cmd_t sc);
      pending_t p;
      @(posedge clk_i);
      #1;
      issue_i     = iss;
      issue_cmd_i = ic;
      slide_i     = sld;
      slide_cmd_i = sc;
      p.issue = iss;
      p.slide = sld & ~iss;                    // Issue wins the cycle
      p.icmd  = ic;
      p.scmd  = sc;
      p.vs1   = rand_lanes();
      p.vs2   = rand_lanes();
      p.vs3   = rand_lanes();
      pend_q.push_back(p);
      exp_d = '0;
      if (pend_q.size() > READ_DELAY)
      begin
         p     = pend_q.pop_front();
         vs1_i = p.vs1;
         vs2_i = p.vs2;
         vs3_i = p.vs3;
         exp_d.res_valid   = p.issue;
         exp_d.slide_valid = p.slide;
         if (p.issue)
         begin
            exp_d.res   = expect_result(p.icmd, p.vs1, p.vs2, p.vs3);
            res_checked = res_checked + 1;
         end
         if (p.slide)
         begin
            exp_d.slide   = expect_slide(p.scmd, p.vs2);
            slide_checked = slide_checked + 1;
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
         drive_cycle(1'b0, '0, 1'b0, '0);
   endtask

   initial
   begin
      issue_cmd_t ic;
      slide_cmd_t sc;
      clk_i         = 1'b0;
      rst_i         = 1'b0;
      issue_i       = 1'b0;
      issue_cmd_i   = '0;
      slide_i       = 1'b0;
      slide_cmd_i   = '0;
      vs1_i         = '0;
      vs2_i         = '0;
      vs3_i         = '0;
      exp_d         = '0;
      lfsr_state    = 16'd19;
      res_errors    = 0;
      slide_errors  = 0;
      res_checked   = 0;
      slide_checked = 0;
      cycle_cnt     = 0;
      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      idle_cycles(4);                          // Valids must stay low here

      // Vector B for every width and opcode back to back
      for (int s = 0; s < 3; s++)
         for (int op = 0; op < 7; op++)
         begin
            ic        = '0;
            ic.opcode = opcode_e'(op);
            ic.sew    = sew_e'(s);
            drive_cycle(1'b1, ic, 1'b0, '0);
         end

      // Scalar and immediate B
      for (int s = 0; s < 3; s++)
         for (int op = 0; op < 7; op++)
            for (int src = 1; src < 3; src++)
            begin
               ic.opcode  = opcode_e'(op);
               ic.sew     = sew_e'(s);
               ic.op2_src = op2_src_e'(src);
               ic.scalar  = rand_bits(32);
               ic.imm     = 5'(rand_bits(5));
               drive_cycle(1'b1, ic, 1'b0, '0);
            end

      // Slides with amounts past NUM_LANES and random ones
      for (int d = 0; d < 2; d++)
         for (int sel = 0; sel < 4; sel++)
         begin
            sc.dir_up   = d[0];
            sc.byte_sel = sel[1:0];
            sc.amount   = 8'(NUM_LANES*(sel+1) + 2*d + 1);
            drive_cycle(1'b0, '0, 1'b1, sc);
            sc.amount   = 8'(rand_bits(8));
            drive_cycle(1'b0, '0, 1'b1, sc);
         end

      drive_cycle(1'b1, ic, 1'b1, sc);         // Slide dropped
      drive_cycle(1'b0, '0, 1'b1, sc);

      // Random commands with gaps
      repeat (8)
      begin
         ic.opcode  = opcode_e'(rand_bits(3) % 7);
         ic.sew     = sew_e'(rand_bits(2) % 3);
         ic.op2_src = op2_src_e'(rand_bits(2) % 3);
         ic.scalar  = rand_bits(32);
         ic.imm     = 5'(rand_bits(5));
         drive_cycle(1'b1, ic, 1'b0, '0);
         idle_cycles(int'(rand_bits(2)));
      end

      idle_cycles(READ_DELAY + 3);
      @(negedge clk_i);
      #1;
      $display("Results checked %0d, slides checked %0d, result errors %0d, slide errors %0d",
               res_checked, slide_checked, res_errors, slide_errors);
      if (res_errors == 0 && slide_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* list.f */
+incdir+verification
logic/lane_cfg_pkg.sv
logic/lane_op_pkg.sv
logic/lane_issue_ctrl.sv
logic/operand_regroup.sv
logic/element_alu.sv
logic/result_scatter.sv
logic/slide_xbar.sv
logic/lane_cluster_top.sv
verification/tb_lane_cluster.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the lane cluster testbench with Verilator and runs it

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_lane_cluster -Mdir obj_dir -o sim_lane
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_lane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF 'All tests passed!' "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
